// File: verilog/fpu_format_pkg.sv
package fpu_format_pkg;

   localparam int EXP_W    = 8;    // Biased exponent
   localparam int FRAC_W   = 23;   // Stored fraction
   localparam int MANT_W   = 24;   // Fraction with hidden bit
   localparam int WIDE_W   = 50;   // Working fraction, leading one at bit 47
   localparam int EXP_BIAS = 127;
   localparam int EXP_MAX  = 255;  // Inf and NaN

   // binary32 as it sits in a register
   typedef struct packed {
      logic              sign;
      logic [EXP_W-1:0]  exp;
      logic [FRAC_W-1:0] frac;
   } fp32_t;

   // Hidden bit restored, zero when the exponent is zero
   typedef struct packed {
      logic              sign;
      logic [EXP_W-1:0]  exp;
      logic [MANT_W-1:0] frac;
   } fp_unpacked_t;

   // Value is +/- frac * 2^(exp - EXP_BIAS - 47)
   typedef struct packed {
      logic              sign;
      logic [EXP_W:0]    exp;   // Read as signed, room for underflow
      logic [WIDE_W-1:0] frac;  // Two's complement while adding
   } fp_wide_t;

   // Subnormals become zero here, once, at operand capture
   function automatic fp_unpacked_t fp_unpack(fp32_t f);
      fp_unpacked_t u;
      u.sign = f.sign;
      u.exp  = f.exp;
      u.frac = (f.exp != '0) ? {1'b1, f.frac} : '0;
      return u;
   endfunction

   function automatic fp32_t fp_pack(fp_unpacked_t u);
      return {u.sign, u.exp, u.frac[FRAC_W-1:0]};  // Hidden bit dropped
   endfunction

endpackage

// File: verilog/fpu_ctrl_pkg.sv
package fpu_ctrl_pkg;

   typedef enum logic [4:0] {
      OP_NONE,    // Unknown or unsupported encoding
      OP_FADD,
      OP_FSUB,
      OP_FMUL,
      OP_FSGNJ,
      OP_FSGNJN,
      OP_FSGNJX,
      OP_FMIN,
      OP_FMAX,
      OP_FEQ,
      OP_FLT,
      OP_FLE,
      OP_FCLASS,
      OP_FMVXW,
      OP_FMVWX
   } fpu_op_e;

   // Execution steps, one per cycle
   typedef enum logic [2:0] {
      STEP_IDLE,
      STEP_LOAD,   // X <- A, Y <- B
      STEP_MUL,    // X <- norm(A*B)
      STEP_SWAP,   // Larger magnitude into Y
      STEP_SHIFT,  // Align X to Y
      STEP_ADD,    // X <- X + Y, count leading zeros
      STEP_NORM,   // Leading one back to bit 47
      STEP_CMP     // Compare, min, max
   } fpu_step_e;

   typedef struct packed {
      fpu_op_e op;
      logic    negate_b;  // FSUB flips the sign of rs2
   } fpu_cmd_t;

   // Ops that run through the sequencer
   function automatic logic op_is_multi(fpu_op_e op);
      return op inside {OP_FADD, OP_FSUB, OP_FMUL, OP_FMIN, OP_FMAX, OP_FEQ, OP_FLT, OP_FLE};
   endfunction

endpackage

// File: verilog/fpu_clz.sv
`timescale 1ns/1ps

module fpu_clz #(
   parameter  int W_IN  = 64,            // Power of two, at least 2
   localparam int W_OUT = $clog2(W_IN)
) (
   input  logic [W_IN-1:0]  in,
   output logic [W_OUT-1:0] count  // All zeros reads as W_IN-1
);

   if (W_IN == 2) begin : g_leaf
      assign count = !in[1];
   end else begin : g_split
      logic [W_IN/2-1:0] hi;
      logic [W_IN/2-1:0] lo;
      logic              hi_empty;
      logic [W_OUT-2:0]  half_count;

      assign hi       = in[W_IN-1 -: W_IN/2];
      assign lo       = in[W_IN/2-1:0];
      assign hi_empty = ~|hi;  // MSB of the count

      fpu_clz #(.W_IN(W_IN/2)) i_half (
         .in    (hi_empty ? lo : hi),
         .count (half_count)
      );

      assign count = {hi_empty, half_count};
   end

endmodule

// File: verilog/fpu_decode.sv
`timescale 1ns/1ps

module fpu_decode
   import fpu_ctrl_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        wr,
   input  logic        busy,
   input  logic [31:2] instr,
   output fpu_cmd_t    now_cmd,  // Decode of the word on the bus
   output fpu_cmd_t    cmd       // Held for the whole sequence
);

   logic [4:0] funct5;
   logic [1:0] funct3;  // Low bits of funct3, all RV32F needs here
   logic       op_fp;   // OP-FP major opcode, fused family has this clear

   assign funct5 = instr[31:27];
   assign funct3 = instr[13:12];
   assign op_fp  = instr[4];

   always_comb begin
      now_cmd.op = OP_NONE;
      if (op_fp) begin
         case (funct5)
            5'b00000: now_cmd.op = OP_FADD;
            5'b00001: now_cmd.op = OP_FSUB;
            5'b00010: now_cmd.op = OP_FMUL;
            5'b00100: begin  // Sign injection
               case (funct3)
                  2'b00:   now_cmd.op = OP_FSGNJ;
                  2'b01:   now_cmd.op = OP_FSGNJN;
                  2'b10:   now_cmd.op = OP_FSGNJX;
                  default: now_cmd.op = OP_NONE;
               endcase
            end
            5'b00101: now_cmd.op = funct3[0] ? OP_FMAX : OP_FMIN;
            5'b10100: begin
               case (funct3)
                  2'b00:   now_cmd.op = OP_FLE;
                  2'b01:   now_cmd.op = OP_FLT;
                  2'b10:   now_cmd.op = OP_FEQ;
                  default: now_cmd.op = OP_NONE;
               endcase
            end
            5'b11100: now_cmd.op = funct3[0] ? OP_FCLASS : OP_FMVXW;  // Same funct7
            5'b11110: now_cmd.op = OP_FMVWX;
            default:  now_cmd.op = OP_NONE;
         endcase
      end
      now_cmd.negate_b = (now_cmd.op == OP_FSUB);
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cmd <= '{op: OP_NONE, negate_b: 1'b0};
      end else if (wr) begin
         cmd <= now_cmd;
      end
   end

   // Only one operation in flight
   a_wr_not_busy: assert property (@(posedge clk) disable iff (!arst_n) wr |-> !busy);

endmodule

// File: verilog/fpu_sequencer.sv
`timescale 1ns/1ps

module fpu_sequencer
   import fpu_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      wr,
   input  fpu_cmd_t  now_cmd,
   input  fpu_cmd_t  cmd,
   output fpu_step_e step,
   output logic      busy
);

   fpu_step_e step_nxt;

   always_comb begin
      step_nxt = STEP_IDLE;
      if (wr) begin
         if (op_is_multi(now_cmd.op))
            step_nxt = STEP_LOAD;  // Single-cycle ops never leave idle
      end else begin
         case (step)
            STEP_LOAD: begin
               case (cmd.op)
                  OP_FMUL:          step_nxt = STEP_MUL;
                  OP_FADD, OP_FSUB: step_nxt = STEP_SWAP;
                  default:          step_nxt = STEP_CMP;  // Compare, min, max
               endcase
            end
            STEP_SWAP:  step_nxt = STEP_SHIFT;
            STEP_SHIFT: step_nxt = STEP_ADD;
            STEP_ADD:   step_nxt = STEP_NORM;
            default:    step_nxt = STEP_IDLE;  // MUL, CMP and NORM are last
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         step <= STEP_IDLE;
      else
         step <= step_nxt;
   end

   assign busy = (step != STEP_IDLE);

   // A sequence only starts from a write, on the command latched with it
   a_start_on_wr: assert property (@(posedge clk) disable iff (!arst_n)
      (step == STEP_LOAD) |-> $past(wr) && (cmd == $past(now_cmd)));

endmodule

// File: verilog/fpu_arith.sv
`timescale 1ns/1ps

module fpu_arith
   import fpu_format_pkg::*, fpu_ctrl_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         wr,
   input  fp32_t        rs1,
   input  fp32_t        rs2,
   input  fpu_cmd_t     cmd,
   input  fpu_step_e    step,
   output fp_unpacked_t x_val,   // X as it leaves the current step
   output fp_unpacked_t y_val,
   output logic         x_lt_y,
   output logic         x_le_y
);

   fp_unpacked_t       a;            // Flushed rs1
   fp_unpacked_t       b;            // Flushed rs2
   fp_wide_t           x;            // Accumulator, shifter side
   fp_wide_t           y;
   fp_wide_t           x_nxt;
   fp_wide_t           y_nxt;
   logic [5:0]         norm_lshamt;  // From ADD to NORM
   logic signed [8:0]  x_exp_norm;   // Exponent once normalized
   logic signed [8:0]  exp_diff;
   logic signed [50:0] frac_diff;
   logic signed [50:0] frac_sum;
   logic [47:0]        prod;
   logic [9:0]         prod_exp;
   logic               prod_z;
   logic [5:0]         sum_clz;
   logic               exp_eq;
   logic               frac_eq;
   logic               y_lt_x_abs;
   logic               y_le_x_abs;
   logic               both_zero;
   logic [WIDE_W-1:0]  x_mag;

   assign exp_diff  = $signed(y.exp) - $signed(x.exp);
   assign frac_diff = $signed({y.frac[WIDE_W-1], y.frac}) - $signed({x.frac[WIDE_W-1], x.frac});
   assign frac_sum  = $signed({y.frac[WIDE_W-1], y.frac}) + $signed({x.frac[WIDE_W-1], x.frac});

   // Product of normals has its leading one at bit 47 or 46
   assign prod     = a.frac * b.frac;
   assign prod_exp = {2'b0, a.exp} + {2'b0, b.exp} - 10'(EXP_BIAS) + {9'b0, prod[47]};
   assign prod_z   = ($signed(prod_exp) <= 0) || !(|prod[47:46]);  // Underflow or zero

   // First set bit of the sum is 63 - clz
   fpu_clz #(.W_IN(64)) i_clz (
      .in    ({13'b0, frac_sum}),
      .count (sum_clz)
   );

   // Magnitude order, valid while both fractions are non-negative
   assign exp_eq     = (exp_diff == 0);
   assign frac_eq    = (frac_diff == 0);
   assign y_lt_x_abs = exp_diff[8] | (exp_eq & frac_diff[50]);
   assign y_le_x_abs = y_lt_x_abs | (exp_eq & frac_eq);
   assign both_zero  = (x.exp == '0) & (y.exp == '0);  // +0 and -0 compare equal

   assign x_lt_y = !both_zero & ((x.sign & !y.sign) |
                                 (x.sign & y.sign & y_lt_x_abs) |
                                 (!x.sign & !y.sign & !y_le_x_abs));
   assign x_le_y = both_zero | (x.sign & !y.sign) |
                   (x.sign & y.sign & y_le_x_abs) |
                   (!x.sign & !y.sign & !y_lt_x_abs);

   always_comb begin
      x_nxt = x;
      y_nxt = y;
      case (step)
         STEP_LOAD: begin
            x_nxt.sign = a.sign;
            x_nxt.exp  = {1'b0, a.exp};
            x_nxt.frac = {2'b0, a.frac, 24'b0};
            y_nxt.sign = b.sign ^ cmd.negate_b;
            y_nxt.exp  = {1'b0, b.exp};
            y_nxt.frac = {2'b0, b.frac, 24'b0};
         end
         STEP_MUL: begin
            x_nxt.sign = a.sign ^ b.sign;
            x_nxt.exp  = prod_z ? '0 : prod_exp[EXP_W:0];
            if (prod_z)
               x_nxt.frac = '0;
            else
               x_nxt.frac = prod[47] ? {2'b0, prod} : {1'b0, prod, 1'b0};
         end
         STEP_SWAP: begin
            // Negate before shifting so truncation goes toward zero
            if (y_lt_x_abs) begin
               x_nxt      = y;
               x_nxt.frac = (x.sign ^ y.sign) ? -y.frac : y.frac;
               y_nxt      = x;
            end else if (x.sign ^ y.sign) begin
               x_nxt.frac = -x.frac;
            end
         end
         STEP_SHIFT: begin
            x_nxt.frac = $signed(x.frac) >>> exp_diff;  // Sign-filling shift
            x_nxt.exp  = y.exp;
         end
         STEP_ADD: begin
            x_nxt.frac = frac_sum[WIDE_W-1:0];  // Never negative here
            x_nxt.sign = y.sign;
         end
         STEP_NORM: begin
            if (x_exp_norm <= 0 || x.frac == '0) begin
               x_nxt = '0;  // Zero and underflow give +0
            end else begin
               x_nxt.frac = x.frac[48] ? (x.frac >> 1) : (x.frac << norm_lshamt);
               x_nxt.exp  = x_exp_norm;
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (wr) begin
         a <= fp_unpack(rs1);
         b <= fp_unpack(rs2);
      end
      x <= x_nxt;
      y <= y_nxt;
      if (step == STEP_ADD) begin
         norm_lshamt <= sum_clz - 6'd16;  // 47 - first set bit
         x_exp_norm  <= $signed(x.exp) + 9'sd16 - $signed({3'b0, sum_clz});
      end
   end

   assign x_val = {x_nxt.sign, x_nxt.exp[EXP_W-1:0], x_nxt.frac[WIDE_W-3 -: MANT_W]};
   assign y_val = {y.sign, y.exp[EXP_W-1:0], y.frac[WIDE_W-3 -: MANT_W]};

   // SWAP must leave the smaller magnitude in X
   assign x_mag = x.frac[WIDE_W-1] ? -x.frac : x.frac;

   a_shift_order: assert property (@(posedge clk) disable iff (!arst_n)
      (step == STEP_SHIFT) |-> !exp_diff[8] && (!exp_eq || (x_mag <= y.frac)));

endmodule

// File: verilog/fpu_result.sv
`timescale 1ns/1ps

module fpu_result
   import fpu_format_pkg::*, fpu_ctrl_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         wr,
   input  fp32_t        rs1,
   input  fp32_t        rs2,
   input  fpu_cmd_t     now_cmd,  // Single-cycle ops act on this
   input  fpu_cmd_t     cmd,
   input  fpu_step_e    step,
   input  fp_unpacked_t x_val,
   input  fp_unpacked_t y_val,
   input  logic         x_lt_y,
   input  logic         x_le_y,
   output logic [31:0]  result
);

   logic         rs1_exp_z;
   logic         rs1_exp_max;
   logic         rs1_frac_z;
   logic [9:0]   fclass;
   logic         last_step;
   logic         cmp_bit;
   fp_unpacked_t pick;

   assign rs1_exp_z   = (rs1.exp == '0);
   assign rs1_exp_max = (rs1.exp == EXP_W'(EXP_MAX));
   assign rs1_frac_z  = (rs1.frac == '0);

   // RV32F class bits, one hot
   assign fclass = {
      rs1_exp_max &  rs1.frac[FRAC_W-1],                 // Quiet NaN
      rs1_exp_max & !rs1.frac[FRAC_W-1] & !rs1_frac_z,   // Signaling NaN
      !rs1.sign &  rs1_exp_max & rs1_frac_z,             // +inf
      !rs1.sign & !rs1_exp_z & !rs1_exp_max,             // +normal
      !rs1.sign &  rs1_exp_z & !rs1_frac_z,              // +subnormal
      !rs1.sign &  rs1_exp_z &  rs1_frac_z,              // +0
       rs1.sign &  rs1_exp_z &  rs1_frac_z,              // -0
       rs1.sign &  rs1_exp_z & !rs1_frac_z,              // -subnormal
       rs1.sign & !rs1_exp_z & !rs1_exp_max,             // -normal
       rs1.sign &  rs1_exp_max & rs1_frac_z              // -inf
   };

   assign last_step = step inside {STEP_MUL, STEP_CMP, STEP_NORM};

   always_comb begin
      case (cmd.op)
         OP_FEQ:  cmp_bit = x_le_y & !x_lt_y;
         OP_FLT:  cmp_bit = x_lt_y;
         OP_FLE:  cmp_bit = x_le_y;
         default: cmp_bit = 1'b0;
      endcase
   end

   assign pick = (x_lt_y ^ (cmd.op == OP_FMAX)) ? x_val : y_val;  // Ties take X on max

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
      end else if (wr) begin
         case (now_cmd.op)
            OP_FSGNJ:           result <= {rs2.sign, rs1.exp, rs1.frac};
            OP_FSGNJN:          result <= {!rs2.sign, rs1.exp, rs1.frac};
            OP_FSGNJX:          result <= {rs1.sign ^ rs2.sign, rs1.exp, rs1.frac};
            OP_FCLASS:          result <= {22'b0, fclass};
            OP_FMVXW, OP_FMVWX: result <= rs1;  // Raw bit move
            default: ;                          // Holds until the sequence ends
         endcase
      end else if (last_step) begin
         case (cmd.op)
            OP_FADD, OP_FSUB, OP_FMUL: result <= fp_pack(x_val);
            OP_FEQ, OP_FLT, OP_FLE:    result <= {31'b0, cmp_bit};
            OP_FMIN, OP_FMAX:          result <= fp_pack(pick);
            default: ;
         endcase
      end
   end

endmodule

// File: verilog/fpu_top.sv
`timescale 1ns/1ps

module fpu_top
   import fpu_format_pkg::*, fpu_ctrl_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        wr,      // One-cycle start strobe
   input  logic [31:2] instr,
   input  logic [31:0] rs1,
   input  logic [31:0] rs2,
   output logic        busy,
   output logic [31:0] result
);

   fpu_cmd_t     now_cmd;
   fpu_cmd_t     cmd;
   fpu_step_e    step;
   fp_unpacked_t x_val;
   fp_unpacked_t y_val;
   logic         x_lt_y;
   logic         x_le_y;

   // Decode stage
   fpu_decode i_decode (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr      (wr),
      .busy    (busy),
      .instr   (instr),
      .now_cmd (now_cmd),
      .cmd     (cmd)
   );

   // Execute stage
   fpu_sequencer i_sequencer (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr      (wr),
      .now_cmd (now_cmd),
      .cmd     (cmd),
      .step    (step),
      .busy    (busy)
   );

   fpu_arith i_arith (
      .clk    (clk),
      .arst_n (arst_n),
      .wr     (wr),
      .rs1    (rs1),
      .rs2    (rs2),
      .cmd    (cmd),
      .step   (step),
      .x_val  (x_val),
      .y_val  (y_val),
      .x_lt_y (x_lt_y),
      .x_le_y (x_le_y)
   );

   // Result stage
   fpu_result i_result (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr      (wr),
      .rs1     (rs1),
      .rs2     (rs2),
      .now_cmd (now_cmd),
      .cmd     (cmd),
      .step    (step),
      .x_val   (x_val),
      .y_val   (y_val),
      .x_lt_y  (x_lt_y),
      .x_le_y  (x_le_y),
      .result  (result)
   );

endmodule

// File: verif/fpu_tb.sv
`timescale 1ns/1ps

module fpu_tb
   import fpu_ctrl_pkg::*;
();

   localparam int          CLK_PERIOD = 100;
   localparam int          DRIVE_DLY  = 5;             // Inputs change after the edge
   localparam int unsigned SEED       = 32'h4f11_0d76;
   localparam int          N_SPECIAL  = 10;
   localparam int          N_RAND     = 12;
   localparam int          N_TESTS    = N_SPECIAL*2 + N_RAND*13 + 17;
   localparam int          WDOG_CYC   = N_TESTS*10 + 100;

   logic        clk;
   logic        arst_n;
   logic        wr;
   logic [31:2] instr;
   logic [31:0] rs1;
   logic [31:0] rs2;
   logic        busy;
   logic [31:0] result;

   // Handed from stimulus to the checker
   event        check_ev;
   string       chk_name;
   logic [31:0] chk_exp;
   logic [31:0] chk_act;
   int          chk_busy_exp;
   int          chk_busy_act;
   logic        check_ok;
   int          n_issued  = 0;
   int          n_checked = 0;
   int          n_pass    = 0;
   int          n_fail    = 0;
   logic [31:0] op_a;
   logic [31:0] op_b;

   // +/-0, +/-subnormal, +/-inf, qNaN, sNaN, +/-normal
   logic [31:0] specials [N_SPECIAL] = '{
      32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 32'h807f_ffff, 32'h7f80_0000,
      32'hff80_0000, 32'h7fc0_0000, 32'h7f80_0001, 32'h3f80_0000, 32'hc120_0000
   };

   fpu_top i_fpu_top (
      .clk    (clk),
      .arst_n (arst_n),
      .wr     (wr),
      .instr  (instr),
      .rs1    (rs1),
      .rs2    (rs2),
      .busy   (busy),
      .result (result)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // OP-FP word, rd=f3, rs1=f1, rs2=f2, single format
   function automatic logic [31:0] encode_instr(fpu_op_e op);
      logic [4:0] funct5;
      logic [2:0] funct3;
      case (op)
         OP_FADD:   {funct5, funct3} = {5'b00000, 3'b000};
         OP_FSUB:   {funct5, funct3} = {5'b00001, 3'b000};
         OP_FMUL:   {funct5, funct3} = {5'b00010, 3'b000};
         OP_FSGNJ:  {funct5, funct3} = {5'b00100, 3'b000};
         OP_FSGNJN: {funct5, funct3} = {5'b00100, 3'b001};
         OP_FSGNJX: {funct5, funct3} = {5'b00100, 3'b010};
         OP_FMIN:   {funct5, funct3} = {5'b00101, 3'b000};
         OP_FMAX:   {funct5, funct3} = {5'b00101, 3'b001};
         OP_FLE:    {funct5, funct3} = {5'b10100, 3'b000};
         OP_FLT:    {funct5, funct3} = {5'b10100, 3'b001};
         OP_FEQ:    {funct5, funct3} = {5'b10100, 3'b010};
         OP_FCLASS: {funct5, funct3} = {5'b11100, 3'b001};
         OP_FMVXW:  {funct5, funct3} = {5'b11100, 3'b000};
         OP_FMVWX:  {funct5, funct3} = {5'b11110, 3'b000};
         default:   {funct5, funct3} = {5'b11111, 3'b111};
      endcase
      return {funct5, 2'b00, 5'd2, 5'd1, funct3, 5'd3, 7'b1010011};
   endfunction

   function automatic int busy_cycles(fpu_op_e op);
      case (op)
         OP_FADD, OP_FSUB:                                  return 5;
         OP_FMUL, OP_FEQ, OP_FLT, OP_FLE, OP_FMIN, OP_FMAX: return 2;
         default:                                           return 0;
      endcase
   endfunction

   function automatic logic [31:0] flush_sub(logic [31:0] v);
      return (v[30:23] == 8'h00) ? {v[31], 31'b0} : v;  // Sign survives
   endfunction

   // Total order of non-NaN values, both zeros on 0
   function automatic longint order_key(logic [31:0] v);
      logic [31:0] f;
      longint      mag;
      f   = flush_sub(v);
      mag = longint'(f[30:0]);
      return f[31] ? -mag : mag;
   endfunction

   function automatic logic [31:0] class_bits(logic [31:0] v);
      int idx;
      if (v[30:23] == 8'hff) begin
         if (v[22:0] == '0)
            idx = v[31] ? 0 : 7;
         else
            idx = v[22] ? 9 : 8;                // Quiet when the top fraction bit is set
      end else if (v[30:23] == 8'h00) begin
         if (v[22:0] == '0)
            idx = v[31] ? 3 : 4;
         else
            idx = v[31] ? 2 : 5;
      end else begin
         idx = v[31] ? 1 : 6;
      end
      return 32'd1 << idx;
   endfunction

   function automatic logic [31:0] mul_trunc(logic [31:0] a, logic [31:0] b);
      logic [31:0] fa;
      logic [31:0] fb;
      logic        s;
      logic [47:0] ma;
      logic [47:0] mb;
      logic [47:0] p;
      logic [22:0] m;
      int          e;
      fa = flush_sub(a);
      fb = flush_sub(b);
      s  = fa[31] ^ fb[31];
      if (fa[30:23] == 8'h00 || fb[30:23] == 8'h00)
         return {s, 31'b0};
      ma = {1'b1, fa[22:0]};
      mb = {1'b1, fb[22:0]};
      p  = ma * mb;                            // Exact, 48 bits
      e  = int'(fa[30:23]) + int'(fb[30:23]) - 127;
      if (p[47]) begin
         e = e + 1;
         m = p[46:24];
      end else begin
         m = p[45:23];
      end
      if (e <= 0)
         return {s, 31'b0};                    // Underflow flushes
      return {s, 8'(e), m};
   endfunction

   // Exact sum on a common scale, then truncate the magnitude
   function automatic logic [31:0] add_trunc(logic [31:0] a, logic [31:0] b);
      logic [31:0] fa;
      logic [31:0] fb;
      logic [63:0] mag;
      logic [63:0] m;
      longint      va;
      longint      vb;
      longint      s;
      int          e0;
      int          p;
      int          er;
      fa = flush_sub(a);
      fb = flush_sub(b);
      if (fa[30:23] == 8'h00 && fb[30:23] == 8'h00)
         return 32'h0;
      if (fa[30:23] == 8'h00)
         return fb;
      if (fb[30:23] == 8'h00)
         return fa;
      e0 = (fa[30:23] < fb[30:23]) ? int'(fa[30:23]) : int'(fb[30:23]);
      va = longint'({1'b1, fa[22:0]}) << (int'(fa[30:23]) - e0);
      vb = longint'({1'b1, fb[22:0]}) << (int'(fb[30:23]) - e0);
      s  = (fa[31] ? -va : va) + (fb[31] ? -vb : vb);
      if (s == 0)
         return 32'h0;                         // Cancellation gives +0
      mag = (s < 0) ? 64'(-s) : 64'(s);
      p   = 0;
      for (int i = 0; i < 64; i++)
         if (mag[i])
            p = i;
      er = e0 + p - 23;
      if (er <= 0)
         return 32'h0;
      m = (p >= 23) ? (mag >> (p - 23)) : (mag << (23 - p));
      return {(s < 0), 8'(er), m[22:0]};
   endfunction

   function automatic logic [31:0] ref_fpu(fpu_op_e op, logic [31:0] a, logic [31:0] b);
      case (op)
         OP_FADD:   return add_trunc(a, b);
         OP_FSUB:   return add_trunc(a, {~b[31], b[30:0]});
         OP_FMUL:   return mul_trunc(a, b);
         OP_FSGNJ:  return {b[31], a[30:0]};
         OP_FSGNJN: return {~b[31], a[30:0]};
         OP_FSGNJX: return {a[31] ^ b[31], a[30:0]};
         OP_FEQ:    return 32'(order_key(a) == order_key(b));
         OP_FLT:    return 32'(order_key(a) < order_key(b));
         OP_FLE:    return 32'(order_key(a) <= order_key(b));
         OP_FMIN:   return (order_key(a) < order_key(b)) ? flush_sub(a) : flush_sub(b);
         OP_FMAX:   return (order_key(a) < order_key(b)) ? flush_sub(b) : flush_sub(a);
         OP_FCLASS: return class_bits(a);
         OP_FMVXW,
         OP_FMVWX:  return a;
         default:   return 32'h0;
      endcase
   endfunction

   function automatic logic [31:0] rand_normal(int lo, int hi);
      return {1'($urandom), 8'(lo + int'($urandom % 32'(hi - lo + 1))), 23'($urandom)};
   endfunction

   // Exponent at most 24 away from the base
   function automatic logic [31:0] rand_near(logic [31:0] base);
      int e;
      e = int'(base[30:23]) + int'($urandom % 32'd49) - 24;
      return {1'($urandom), 8'(e), 23'($urandom)};
   endfunction

   // Entered and left at DRIVE_DLY after an edge with busy low
   task automatic run_test(input string name, input fpu_op_e op,
                           input logic [31:0] a, input logic [31:0] b);
      logic [31:0] word;
      int          cycles;
      word  = encode_instr(op);
      instr = word[31:2];
      rs1   = a;
      rs2   = b;
      wr    = 1'b1;
      @(posedge clk);
      #DRIVE_DLY;
      wr     = 1'b0;
      cycles = 0;
      while (busy) begin                       // Watchdog bounds this
         cycles++;
         @(posedge clk);
         #DRIVE_DLY;
      end
      chk_name     = name;
      chk_exp      = ref_fpu(op, a, b);
      chk_act      = result;
      chk_busy_exp = busy_cycles(op);
      chk_busy_act = cycles;
      n_issued++;
      -> check_ev;
   endtask

   always @(check_ev) begin
      check_ok = 1'b1;
      assert (chk_act === chk_exp) else begin
         $display("** Error: %s: expected %h, actual %h", chk_name, chk_exp, chk_act);
         check_ok = 1'b0;
      end
      assert (chk_busy_act == chk_busy_exp) else begin
         $display("** Error: %s: busy cycles expected %0d, actual %0d",
                  chk_name, chk_busy_exp, chk_busy_act);
         check_ok = 1'b0;
      end
      if (check_ok) begin
         n_pass++;
         $display("ok   %s", chk_name);
      end else begin
         n_fail++;
      end
      n_checked++;
   end

   initial begin
      void'($urandom(SEED));
      arst_n = 1'b0;
      wr     = 1'b0;
      instr  = '0;
      rs1    = '0;
      rs2    = '0;
      repeat (10) @(posedge clk);
      #DRIVE_DLY;
      arst_n = 1'b1;
      @(posedge clk);
      #DRIVE_DLY;

      for (int i = 0; i < N_SPECIAL; i++) begin  // Special patterns
         run_test($sformatf("fclass_%0d", i), OP_FCLASS, specials[i], $urandom);
         run_test($sformatf("fsgnjx_spec_%0d", i), OP_FSGNJX, specials[i], $urandom);
      end
      for (int i = 0; i < N_RAND; i++) begin
         op_a = $urandom;
         op_b = $urandom;
         run_test($sformatf("fsgnj_%0d", i), OP_FSGNJ, op_a, op_b);
         run_test($sformatf("fsgnjn_%0d", i), OP_FSGNJN, op_a, op_b);
         run_test($sformatf("fsgnjx_%0d", i), OP_FSGNJX, op_a, op_b);
         run_test($sformatf("fmvxw_%0d", i), OP_FMVXW, op_a, op_b);
         run_test($sformatf("fmvwx_%0d", i), OP_FMVWX, op_a, op_b);
      end

      for (int i = 0; i < N_RAND; i++)         // Product exponent in range
         run_test($sformatf("fmul_%0d", i), OP_FMUL, rand_normal(64, 190), rand_normal(64, 190));
      run_test("fmul_underflow", OP_FMUL, 32'h0080_0000, 32'h3e80_0000);
      run_test("fmul_sub_a", OP_FMUL, 32'h0012_3456, 32'h4040_0000);
      run_test("fmul_sub_b", OP_FMUL, 32'h3fc0_0000, 32'h8000_0abc);

      for (int i = 0; i < N_RAND; i++) begin
         op_a = rand_normal(30, 200);
         run_test($sformatf("fadd_%0d", i), OP_FADD, op_a, rand_near(op_a));
         op_a = rand_normal(30, 200);
         run_test($sformatf("fsub_%0d", i), OP_FSUB, op_a, rand_near(op_a));
      end
      op_a = rand_normal(30, 200);
      run_test("cancel_same", OP_FSUB, op_a, op_a);
      run_test("cancel_neg", OP_FADD, op_a, {~op_a[31], op_a[30:0]});
      run_test("cancel_lsb", OP_FSUB, op_a, op_a ^ 32'h1);
      run_test("cancel_one", OP_FSUB, 32'h3f80_0000, 32'h3f7f_ffff);
      run_test("fadd_sub", OP_FADD, 32'h0040_0000, 32'h4120_0000);
      run_test("fsub_sub_sub", OP_FSUB, 32'h0000_0001, 32'h8040_0000);

      for (int i = 0; i < N_RAND; i++) begin
         op_a = rand_normal(1, 254);
         op_b = (i % 3 == 0) ? {op_a[31:23], 23'($urandom)} : rand_normal(1, 254);
         run_test($sformatf("feq_%0d", i), OP_FEQ, op_a, op_b);
         run_test($sformatf("flt_%0d", i), OP_FLT, op_a, op_b);
         run_test($sformatf("fle_%0d", i), OP_FLE, op_a, op_b);
      end
      op_a = rand_normal(1, 254);
      run_test("feq_same", OP_FEQ, op_a, op_a);
      run_test("flt_same", OP_FLT, op_a, op_a);
      run_test("fle_same", OP_FLE, op_a, op_a);
      run_test("feq_zeros", OP_FEQ, 32'h0000_0000, 32'h8000_0000);
      run_test("flt_zeros", OP_FLT, 32'h0000_0000, 32'h8000_0000);
      run_test("fle_zeros", OP_FLE, 32'h8000_0000, 32'h0000_0000);

      for (int i = 0; i < N_RAND; i++) begin
         op_a = rand_normal(1, 254);
         op_b = rand_normal(1, 254);
         run_test($sformatf("fmin_%0d", i), OP_FMIN, op_a, op_b);
         run_test($sformatf("fmax_%0d", i), OP_FMAX, op_a, op_b);
      end
      run_test("fmin_same", OP_FMIN, op_a, op_a);
      run_test("fmax_same", OP_FMAX, op_b, op_b);

      wait (n_checked == n_issued);
      $display("%0d tests, %0d passed, %0d failed", n_checked, n_pass, n_fail);
      if (n_fail == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // Ten cycles per test is well above the longest sequence
   initial begin
      #(WDOG_CYC * CLK_PERIOD);
      $display("Timeout: the DUT did not finish %0d tests within %0d cycles", N_TESTS, WDOG_CYC);
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: list.f
verilog/fpu_format_pkg.sv
verilog/fpu_ctrl_pkg.sv
verilog/fpu_clz.sv
verilog/fpu_decode.sv
verilog/fpu_sequencer.sv
verilog/fpu_arith.sv
verilog/fpu_result.sv
verilog/fpu_top.sv
verif/fpu_tb.sv

// File: Bender.yml
package:
  name: fpu

sources:
  - verilog/fpu_format_pkg.sv
  - verilog/fpu_ctrl_pkg.sv
  - verilog/fpu_clz.sv
  - verilog/fpu_decode.sv
  - verilog/fpu_sequencer.sv
  - verilog/fpu_arith.sv
  - verilog/fpu_result.sv
  - verilog/fpu_top.sv
  - target: test
    files:
      - verif/fpu_tb.sv
